// ==== flist.f ====
+incdir+include
verilog/dma_pkg.sv
verilog/dma_word_fifo.sv
verilog/dma_bus_fsm.sv
verilog/dma_bus_top.sv
dv/tb_dma_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the dma bus testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_dma_bus \
	-o sim_dma_bus > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_dma_bus > sim.log 2>&1
grep -qx "Everything OK" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== dv/tb_dma_bus.sv ====
// dma bus engine testbench
`timescale 1ns/1ps
`include "dma_settings.svh"

module tb_dma_bus
	import dma_pkg::*;
();

	localparam int DW = `DMA_DATA_WIDTH;
	localparam int NQ = `NUM_CPU_QUEUES;

	logic                   cpci_clk;
	logic                   cpci_reset;
	dma_op_e                dma_op_code_req;
	dma_op_e                dma_op_code_ack;
	logic [3:0]             dma_op_queue_id;
	logic                   dma_vld_c2n;
	logic [DW-1:0]          dma_data_c2n;
	logic                   dma_dest_q_nearly_full_c2n;
	logic                   dma_dest_q_nearly_full_n2c;
	logic                   dma_vld_n2c;
	logic [DW-1:0]          dma_data_n2c;
	logic                   dma_data_tri_en;
	logic [NQ-1:0]          cpu_q_dma_pkt_avail;
	logic [NQ-1:0]          cpu_q_dma_nearly_full;
	logic                   enable_dma;
	logic                   core_tx_rd;
	tx_word_t               core_tx_word;
	logic                   core_tx_empty;
	logic                   core_rx_wr;
	rx_word_t               core_rx_word;
	logic                   core_rx_full;

	tx_word_t      tx_exp[$];     // expected transmit fifo words
	tx_word_t      tx_got[$];     // words the core popped
	logic [DW-1:0] n2c_exp[$];
	logic [DW-1:0] n2c_got[$];    // words the host saw with vld_n2c
	logic [DW-1:0] host_words[$]; // c2n packet with the length word first
	rx_word_t      rx_pkt[$];     // n2c packet with the length word first
	rx_word_t      rx_load[$];    // still to be written into the receive fifo
	logic          bp_on;         // back-pressure mode

	int errors;
	int tests;
	int tests_failed;
	int test_start_errors;

	dma_bus_top DUT (.*);

	initial begin
		cpci_clk = 1'b0;
		forever #4 cpci_clk = ~cpci_clk;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	// avail in 19..16, nearly full in 3..0
	function automatic logic [DW-1:0] status_ref(input logic [NQ-1:0] avail,
		input logic [NQ-1:0] nfull);
		logic [DW-1:0] w;
		int            q;
		w = '0;
		for (q = 0; q < NQ; q++) begin
			w[16 + q] = avail[q];
			w[q]      = nfull[q];
		end
		return w;
	endfunction

	function automatic tx_word_t req_ref(input logic [3:0] qid, input logic n2c);
		tx_word_t w;
		w           = '0;
		w.is_req    = 1'b1;
		w.eop_dir   = n2c; // direction of the request
		w.data[3:0] = qid;
		return w;
	endfunction

	function automatic int data_words(input int len);
		return (len + 3) / 4; // four bytes per word
	endfunction

	// host packet as it lands in the transmit fifo
	function automatic void c2n_ref(input logic [3:0] qid, input int len);
		tx_word_t w;
		int       n;
		int       i;
		n = data_words(len);
		tx_exp.push_back(req_ref(qid, 1'b0));
		w         = '0;
		w.eop_dir = (len == 0); // empty packet ends on the length word
		w.data    = host_words[0];
		tx_exp.push_back(w);
		for (i = 1; i <= n; i++) begin
			w      = '0;
			w.data = host_words[i];
			if (i == n) begin
				w.eop_dir     = 1'b1;
				w.valid_bytes = 2'(len % 4); // full last word is 00
			end
			tx_exp.push_back(w);
		end
	endfunction

	// core packet as the host sees it on the pins
	function automatic void n2c_ref(input logic [3:0] qid, input int len);
		int i;
		tx_exp.push_back(req_ref(qid, 1'b1));
		for (i = 0; i <= data_words(len); i++)
			n2c_exp.push_back(rx_pkt[i].data);
	endfunction

	//////////////////////////////////////////////////
	// core side model and host flow control pins
	//////////////////////////////////////////////////
	initial begin : core_model
		int   rx_count; // receive fifo fill after the last edge
		logic nf_prev;  // nearly full pin as the fsm last sampled it
		rx_count                   = 0;
		nf_prev                    = 1'b0;
		core_tx_rd                 = 1'b0;
		core_rx_wr                 = 1'b0;
		core_rx_word               = '0;
		dma_dest_q_nearly_full_c2n = 1'b0;
		forever begin
			@(posedge cpci_clk);
			#1;
			// take the head now and it pops at the next edge
			if (!cpci_reset && !core_tx_empty && ($urandom % 4 != 0)) begin
				tx_got.push_back(core_tx_word);
				core_tx_rd = 1'b1;
			end else begin
				core_tx_rd = 1'b0;
			end
			if (core_rx_wr)
				rx_count++;
			if (dma_vld_n2c && dma_op_code_ack == OP_TRANSF_N2C) begin
				n2c_got.push_back(dma_data_n2c); // query words filtered out
				rx_count--;
				assert (!nf_prev) else begin
					$display("error %0t: n2c word sent while the host reported nearly full",
						$time);
					errors++;
				end
			end
			if (cpci_reset) begin
				rx_count = 0;
			end else begin
				assert (core_rx_full == (rx_count == `RX_FIFO_DEPTH)) else begin
					$display("error %0t: core_rx_full %b with %0d words held", $time,
						core_rx_full, rx_count);
					errors++;
				end
			end
			if (rx_load.size() != 0 && !core_rx_full && !(bp_on && $urandom % 2 == 0)) begin
				core_rx_word = rx_load.pop_front();
				core_rx_wr   = 1'b1;
			end else begin
				core_rx_wr = 1'b0; // gap
			end
			nf_prev                    = dma_dest_q_nearly_full_c2n;
			dma_dest_q_nearly_full_c2n = bp_on && ($urandom % 3 == 0);
		end
	end

	// compare as soon as both sides have a word
	initial begin : compare_words
		tx_word_t      te;
		tx_word_t      tw;
		logic [DW-1:0] ne;
		logic [DW-1:0] nw;
		forever begin
			@(posedge cpci_clk);
			#2;
			while (tx_exp.size() != 0 && tx_got.size() != 0) begin
				te = tx_exp.pop_front();
				tw = tx_got.pop_front();
				assert (tw == te) else begin
					$display("error %0t: transmit fifo word %h, expected %h", $time, tw, te);
					errors++;
				end
			end
			while (n2c_exp.size() != 0 && n2c_got.size() != 0) begin
				ne = n2c_exp.pop_front();
				nw = n2c_got.pop_front();
				assert (nw == ne) else begin
					$display("error %0t: n2c pin word %h, expected %h", $time, nw, ne);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// host side tasks
	//////////////////////////////////////////////////
	task automatic apply_reset();
		cpci_reset = 1'b1;
		repeat (8) @(posedge cpci_clk);
		#1;
		cpci_reset = 1'b0;
	endtask

	task automatic wait_ack(input dma_op_e op);
		int cyc;
		cyc = 0;
		while (dma_op_code_ack != op && cyc < 50) begin
			@(posedge cpci_clk);
			#1;
			cyc++;
		end
		if (dma_op_code_ack != op) begin
			$display("ack did not change to %s within 50 cycles", op.name());
			errors++;
		end
	endtask

	// go through the query state so any op can follow any other
	task automatic start_op(input dma_op_e op, input logic [3:0] qid);
		dma_op_code_req = OP_STATUS_QUERY;
		wait_ack(OP_STATUS_QUERY);
		if (op != OP_STATUS_QUERY) begin
			dma_op_code_req = op;
			dma_op_queue_id = qid;
			wait_ack(op);
		end
	endtask

	task automatic wait_drained();
		int cyc;
		cyc = 0;
		while ((tx_exp.size() != 0 || n2c_exp.size() != 0) && cyc < 4000) begin
			@(posedge cpci_clk);
			#1;
			cyc++;
		end
		if (tx_exp.size() != 0 || n2c_exp.size() != 0) begin
			$display("expected words still missing after 4000 cycles");
			errors++;
		end
	endtask

	task automatic c2n_transfer(input int len);
		logic [3:0] qid;
		int         i;
		int         idx;
		int         cyc;
		qid = 4'($urandom);
		host_words.delete();
		host_words.push_back(DW'(len));
		for (i = 0; i < data_words(len); i++)
			host_words.push_back($urandom);
		c2n_ref(qid, len);
		start_op(OP_TRANSF_C2N, qid);
		idx = 0;
		cyc = 0;
		while (idx < host_words.size() && cyc < 2000) begin
			@(posedge cpci_clk);
			#1;
			cyc++;
			// hold off while the card reports nearly full
			if (!dma_dest_q_nearly_full_n2c && ($urandom % 4 != 0)) begin
				dma_vld_c2n  = 1'b1;
				dma_data_c2n = host_words[idx];
				idx++;
			end else begin
				dma_vld_c2n = 1'b0;
			end
		end
		@(posedge cpci_clk);
		#1;
		dma_vld_c2n = 1'b0;
		if (idx < host_words.size()) begin
			$display("host could not send all %0d c2n words", host_words.size());
			errors++;
		end
		wait_drained();
	endtask

	task automatic n2c_transfer(input int len);
		logic [3:0] qid;
		rx_word_t   w;
		int         i;
		qid = 4'($urandom);
		rx_pkt.delete();
		w      = '0;
		w.eop  = (len == 0);
		w.data = DW'(len); // length word
		rx_pkt.push_back(w);
		for (i = 1; i <= data_words(len); i++) begin
			w      = '0;
			w.data = $urandom;
			if (i == data_words(len)) begin
				w.eop         = 1'b1;
				w.valid_bytes = 2'(len % 4);
			end
			rx_pkt.push_back(w);
		end
		n2c_ref(qid, len);
		for (i = 0; i < rx_pkt.size(); i++)
			rx_load.push_back(rx_pkt[i]);
		start_op(OP_TRANSF_N2C, qid);
		wait_drained();
	endtask

	// leftovers mean lost or duplicated words
	task automatic end_test(input string name);
		repeat (8) @(posedge cpci_clk);
		#1;
		assert (tx_got.size() == 0 && n2c_got.size() == 0 && rx_load.size() == 0)
		else begin
			$display("extra words left over: %0d at the core, %0d at the host, %0d unloaded",
				tx_got.size(), n2c_got.size(), rx_load.size());
			errors++;
		end
		tx_exp.delete();
		tx_got.delete();
		n2c_exp.delete();
		n2c_got.delete();
		rx_load.delete();
		tests++;
		if (errors != test_start_errors)
			tests_failed++;
		$display("test %-14s %s", name, (errors == test_start_errors) ? "passed" : "failed");
		test_start_errors = errors;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////
	initial begin : stimulus
		int i;
		void'($urandom(36));
		cpci_reset            = 1'b1;
		dma_op_code_req       = OP_IDLE;
		dma_op_queue_id       = 4'h0;
		dma_vld_c2n           = 1'b0;
		dma_data_c2n          = '0;
		cpu_q_dma_pkt_avail   = '0;
		cpu_q_dma_nearly_full = '0;
		enable_dma            = 1'b1;
		bp_on                 = 1'b0;
		errors                = 0;
		tests                 = 0;
		tests_failed          = 0;
		test_start_errors     = 0;
		apply_reset();

		assert (dma_op_code_ack == OP_IDLE && !dma_vld_n2c && !dma_data_tri_en && core_tx_empty
			&& dma_data_n2c == '0 && !dma_dest_q_nearly_full_n2c)
		else begin
			$display("error %0t: after reset ack %s vld %b tri_en %b tx_empty %b", $time,
				dma_op_code_ack.name(), dma_vld_n2c, dma_data_tri_en, core_tx_empty);
			errors++;
		end
		end_test("reset");

		// status word follows the flags one edge later
		cpu_q_dma_pkt_avail   = NQ'($urandom);
		cpu_q_dma_nearly_full = NQ'($urandom);
		start_op(OP_STATUS_QUERY, 4'h0);
		for (i = 0; i < 6; i++) begin
			assert (dma_vld_n2c && dma_data_tri_en && dma_op_code_ack == OP_STATUS_QUERY
				&& dma_data_n2c == status_ref(cpu_q_dma_pkt_avail, cpu_q_dma_nearly_full))
			else begin
				$display("error %0t: status word %h, expected %h", $time, dma_data_n2c,
					status_ref(cpu_q_dma_pkt_avail, cpu_q_dma_nearly_full));
				errors++;
			end
			cpu_q_dma_pkt_avail   = NQ'($urandom);
			cpu_q_dma_nearly_full = NQ'($urandom);
			@(posedge cpci_clk);
			#1;
		end
		end_test("status query");

		for (i = 0; i <= 8; i++)
			c2n_transfer(i);
		for (i = 0; i < 6; i++)
			c2n_transfer(1 + int'($urandom % 200));
		end_test("c2n transfers");

		for (i = 0; i <= 8; i++)
			n2c_transfer(i);
		for (i = 0; i < 4; i++)
			n2c_transfer(1 + int'($urandom % 200));
		end_test("n2c transfers");

		bp_on = 1'b1;
		for (i = 0; i < 6; i++)
			n2c_transfer(1 + int'($urandom % 200));
		bp_on = 1'b0;
		end_test("back-pressure");

		// engine held off and requests go nowhere
		dma_op_code_req = OP_IDLE;
		enable_dma      = 1'b0;
		apply_reset();
		for (i = 0; i < 48; i++) begin
			dma_op_code_req = dma_op_e'(2'(1 + i / 16)); // query, c2n, then n2c
			dma_op_queue_id = 4'($urandom);
			@(posedge cpci_clk);
			#1;
			assert (dma_op_code_ack == OP_IDLE && core_tx_empty && !dma_data_tri_en)
			else begin
				$display("error %0t: engine answered with enable low, ack %s", $time,
					dma_op_code_ack.name());
				errors++;
			end
		end
		dma_op_code_req = OP_IDLE;
		end_test("enable low");

		$display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== verilog/dma_bus_top.sv ====
// cpci dma bus engine top
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_bus_top
	import dma_pkg::*;
(
	// host pins
	input  dma_op_e                    dma_op_code_req,
	input  logic [3:0]                 dma_op_queue_id,
	output dma_op_e                    dma_op_code_ack,
	input  logic                       dma_vld_c2n,
	input  logic [`DMA_DATA_WIDTH-1:0] dma_data_c2n,
	output logic                       dma_dest_q_nearly_full_n2c,
	output logic                       dma_vld_n2c,
	output logic [`DMA_DATA_WIDTH-1:0] dma_data_n2c,
	input  logic                       dma_dest_q_nearly_full_c2n,
	output logic                       dma_data_tri_en,
	// core flags
	input  logic [`NUM_CPU_QUEUES-1:0] cpu_q_dma_pkt_avail,
	input  logic [`NUM_CPU_QUEUES-1:0] cpu_q_dma_nearly_full,
	input  logic                       enable_dma,
	// core drains the transmit fifo
	input  logic                       core_tx_rd,
	output tx_word_t                   core_tx_word,
	output logic                       core_tx_empty,
	// core fills the receive fifo
	input  logic                       core_rx_wr,
	input  rx_word_t                   core_rx_word,
	output logic                       core_rx_full,
	input  logic                       cpci_clk,
	input  logic                       cpci_reset
);

	logic     txfifo_wr;
	tx_word_t txfifo_word;
	logic     txfifo_nearly_full;
	logic     rxfifo_rd_inc;
	rx_word_t rxfifo_word;
	logic     rxfifo_empty;

	//////////////////////////////////////////////////
	// bus fsm
	//////////////////////////////////////////////////
	dma_bus_fsm u_fsm (
		.dma_op_code_req            (dma_op_code_req),
		.dma_op_queue_id            (dma_op_queue_id),
		.dma_vld_c2n                (dma_vld_c2n),
		.dma_data_c2n               (dma_data_c2n),
		.dma_dest_q_nearly_full_c2n (dma_dest_q_nearly_full_c2n),
		.dma_op_code_ack            (dma_op_code_ack),
		.dma_dest_q_nearly_full_n2c (dma_dest_q_nearly_full_n2c),
		.dma_vld_n2c                (dma_vld_n2c),
		.dma_data_n2c               (dma_data_n2c),
		.dma_data_tri_en            (dma_data_tri_en),
		.cpu_q_dma_pkt_avail        (cpu_q_dma_pkt_avail),
		.cpu_q_dma_nearly_full      (cpu_q_dma_nearly_full),
		.enable_dma                 (enable_dma),
		.txfifo_nearly_full         (txfifo_nearly_full),
		.txfifo_wr                  (txfifo_wr),
		.txfifo_word                (txfifo_word),
		.rxfifo_empty               (rxfifo_empty),
		.rxfifo_word                (rxfifo_word),
		.rxfifo_rd_inc              (rxfifo_rd_inc),
		.cpci_clk                   (cpci_clk),
		.cpci_reset                 (cpci_reset)
	);

	// fsm writes, core pops
	dma_word_fifo #(
		.WIDTH              ($bits(tx_word_t)),
		.DEPTH              (`TX_FIFO_DEPTH),
		.NEARLY_FULL_MARGIN (`FIFO_NEARLY_FULL_MARGIN)
	) tx_fifo (
		.cpci_clk    (cpci_clk),
		.cpci_reset  (cpci_reset),
		.wr          (txfifo_wr),
		.wr_data     (txfifo_word),
		.rd          (core_tx_rd),
		.rd_data     (core_tx_word),
		.full        (),
		.nearly_full (txfifo_nearly_full), // host flow control
		.empty       (core_tx_empty)
	);

	// core writes, fsm pops
	dma_word_fifo #(
		.WIDTH              ($bits(rx_word_t)),
		.DEPTH              (`RX_FIFO_DEPTH),
		.NEARLY_FULL_MARGIN (`FIFO_NEARLY_FULL_MARGIN)
	) rx_fifo (
		.cpci_clk    (cpci_clk),
		.cpci_reset  (cpci_reset),
		.wr          (core_rx_wr),
		.wr_data     (core_rx_word),
		.rd          (rxfifo_rd_inc),
		.rd_data     (rxfifo_word),
		.full        (core_rx_full),
		.nearly_full (),
		.empty       (rxfifo_empty)
	);

endmodule

// ==== verilog/dma_bus_fsm.sv ====
// cpci dma bus state machine
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_bus_fsm
	import dma_pkg::*;
(
	// host pins, towards card
	input  dma_op_e                     dma_op_code_req,
	input  logic [3:0]                  dma_op_queue_id,
	input  logic                        dma_vld_c2n,
	input  logic [`DMA_DATA_WIDTH-1:0]  dma_data_c2n,
	input  logic                        dma_dest_q_nearly_full_c2n,
	// card pins, towards host
	output dma_op_e                     dma_op_code_ack,
	output logic                        dma_dest_q_nearly_full_n2c,
	output logic                        dma_vld_n2c,
	output logic [`DMA_DATA_WIDTH-1:0]  dma_data_n2c,
	output logic                        dma_data_tri_en,
	// core flags
	input  logic [`NUM_CPU_QUEUES-1:0]  cpu_q_dma_pkt_avail,
	input  logic [`NUM_CPU_QUEUES-1:0]  cpu_q_dma_nearly_full,
	input  logic                        enable_dma,
	// transmit fifo write side
	input  logic                        txfifo_nearly_full,
	output logic                        txfifo_wr,
	output tx_word_t                    txfifo_word,
	// receive fifo read side
	input  logic                        rxfifo_empty,
	input  rx_word_t                    rxfifo_word,
	output logic                        rxfifo_rd_inc,
	input  logic                        cpci_clk,
	input  logic                        cpci_reset
);

	localparam logic [`PKT_LEN_CNT_WIDTH-1:0] WORD_BYTES =
		`PKT_LEN_CNT_WIDTH'(`DMA_DATA_WIDTH / 8);

	//////////////////////////////////////////////////
	// pin sampling
	//////////////////////////////////////////////////
	dma_op_e                    op_code_req_d;
	logic [3:0]                 queue_id_d;
	logic                       vld_c2n_d;
	logic [`DMA_DATA_WIDTH-1:0] data_c2n_d;
	logic                       dest_nf_c2n_d;

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			op_code_req_d <= OP_IDLE;
			vld_c2n_d     <= 1'b0;
			dest_nf_c2n_d <= 1'b0;
		end else begin
			op_code_req_d <= dma_op_code_req;
			vld_c2n_d     <= dma_vld_c2n;
			dest_nf_c2n_d <= dma_dest_q_nearly_full_c2n;
		end
	end

	always_ff @(posedge cpci_clk) begin // payload pins
		queue_id_d <= dma_op_queue_id;
		data_c2n_d <= dma_data_c2n;
	end

	//////////////////////////////////////////////////
	// state and next values
	//////////////////////////////////////////////////
	dma_state_e                   state, state_nxt;
	dma_op_e                      ack_nxt;
	logic                         vld_n2c_nxt;
	logic                         tri_en_nxt;
	logic [`DMA_DATA_WIDTH-1:0]   data_n2c_nxt;
	logic [`DMA_DATA_WIDTH-1:0]   status_word;
	logic [`PKT_LEN_CNT_WIDTH-1:0] tx_pkt_len, tx_pkt_len_nxt; // c2n bytes left
	logic [`PKT_LEN_CNT_WIDTH-1:0] rx_pkt_len, rx_pkt_len_nxt; // n2c bytes left
	logic                         tx_last_word;
	logic                         rx_last_word;
	logic                         rx_pop_ok;

	assign tx_last_word = (tx_pkt_len <= WORD_BYTES);
	assign rx_last_word = (rx_pkt_len <= WORD_BYTES);
	assign rx_pop_ok    = !rxfifo_empty && !dest_nf_c2n_d; // word ready and host has room

	// pkt_avail in 19..16, nearly_full in 3..0
	always_comb begin
		status_word = '0;
		status_word[16 +: `NUM_CPU_QUEUES] = cpu_q_dma_pkt_avail;
		status_word[0 +: `NUM_CPU_QUEUES]  = cpu_q_dma_nearly_full;
	end

	always_comb begin
		state_nxt      = state;
		ack_nxt        = dma_op_code_ack;
		vld_n2c_nxt    = 1'b0; // only on query or pop
		tri_en_nxt     = dma_data_tri_en;
		data_n2c_nxt   = '0;
		tx_pkt_len_nxt = tx_pkt_len;
		rx_pkt_len_nxt = rx_pkt_len;
		txfifo_wr      = 1'b0;
		txfifo_word    = '0;
		rxfifo_rd_inc  = 1'b0;

		unique case (state)
			ST_IDLE: begin
				if (enable_dma) begin
					case (op_code_req_d)
						OP_STATUS_QUERY: state_nxt = ST_QUERY;
						OP_TRANSF_C2N:   state_nxt = ST_C2N_QID;
						OP_TRANSF_N2C:   state_nxt = ST_N2C_QID;
						default:         state_nxt = ST_IDLE;
					endcase
				end
			end

			ST_QUERY: begin
				ack_nxt      = OP_STATUS_QUERY;
				tri_en_nxt   = 1'b1; // card drives the bus
				vld_n2c_nxt  = 1'b1;
				data_n2c_nxt = status_word;
				if (op_code_req_d == OP_TRANSF_C2N)
					state_nxt = ST_C2N_QID;
				else if (op_code_req_d == OP_TRANSF_N2C)
					state_nxt = ST_N2C_QID;
			end

			// host to card
			ST_C2N_QID: begin
				ack_nxt                = OP_TRANSF_C2N;
				tri_en_nxt             = 1'b0; // host drives
				txfifo_wr              = 1'b1;
				txfifo_word.is_req     = 1'b1;
				txfifo_word.eop_dir    = 1'b0; // c2n request
				txfifo_word.data[3:0]  = queue_id_d;
				state_nxt              = ST_C2N_LEN;
			end

			ST_C2N_LEN: begin
				if (vld_c2n_d) begin
					tx_pkt_len_nxt      = data_c2n_d[`PKT_LEN_CNT_WIDTH-1:0];
					txfifo_wr           = 1'b1;
					txfifo_word.data    = data_c2n_d;
					txfifo_word.eop_dir = (tx_pkt_len_nxt == '0); // empty packet
					state_nxt = (tx_pkt_len_nxt == '0) ? ST_C2N_DONE : ST_C2N_DATA;
				end
			end

			ST_C2N_DATA: begin
				if (vld_c2n_d) begin
					txfifo_wr        = 1'b1;
					txfifo_word.data = data_c2n_d;
					if (tx_last_word) begin
						txfifo_word.eop_dir     = 1'b1;
						txfifo_word.valid_bytes = tx_pkt_len[1:0]; // 4 wraps to 00
						tx_pkt_len_nxt          = '0;
						state_nxt               = ST_C2N_DONE;
					end else begin
						tx_pkt_len_nxt = tx_pkt_len - WORD_BYTES;
					end
				end
			end

			ST_C2N_DONE: begin
				if (op_code_req_d == OP_STATUS_QUERY)
					state_nxt = ST_QUERY;
				else if (op_code_req_d == OP_TRANSF_N2C)
					state_nxt = ST_N2C_QID;
			end

			// card to host
			ST_N2C_QID: begin
				ack_nxt               = OP_TRANSF_N2C;
				tri_en_nxt            = 1'b1; // turn bus around
				rx_pkt_len_nxt        = '0;
				txfifo_wr             = 1'b1;
				txfifo_word.is_req    = 1'b1;
				txfifo_word.eop_dir   = 1'b1; // n2c request
				txfifo_word.data[3:0] = queue_id_d;
				state_nxt             = ST_N2C_LEN;
			end

			ST_N2C_LEN: begin
				if (rx_pop_ok) begin
					rxfifo_rd_inc  = 1'b1;
					vld_n2c_nxt    = 1'b1;
					data_n2c_nxt   = rxfifo_word.data;
					rx_pkt_len_nxt = rxfifo_word.data[`PKT_LEN_CNT_WIDTH-1:0];
					state_nxt = (rx_pkt_len_nxt == '0) ? ST_N2C_DONE : ST_N2C_DATA;
				end
			end

			ST_N2C_DATA: begin
				if (rx_pop_ok) begin
					rxfifo_rd_inc = 1'b1;
					vld_n2c_nxt   = 1'b1;
					data_n2c_nxt  = rxfifo_word.data;
					if (rx_last_word) begin
						rx_pkt_len_nxt = '0;
						state_nxt      = ST_N2C_DONE;
					end else begin
						rx_pkt_len_nxt = rx_pkt_len - WORD_BYTES;
					end
				end
			end

			ST_N2C_DONE: begin
				if (op_code_req_d == OP_STATUS_QUERY)
					state_nxt = ST_QUERY;
				else if (op_code_req_d == OP_TRANSF_C2N)
					state_nxt = ST_C2N_QID;
			end

			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			state                      <= ST_IDLE;
			dma_op_code_ack            <= OP_IDLE;
			dma_vld_n2c                <= 1'b0;
			dma_data_tri_en            <= 1'b0;
			dma_data_n2c               <= '0;
			dma_dest_q_nearly_full_n2c <= 1'b0;
			tx_pkt_len                 <= '0;
			rx_pkt_len                 <= '0;
		end else begin
			state                      <= state_nxt;
			dma_op_code_ack            <= ack_nxt;
			dma_vld_n2c                <= vld_n2c_nxt;
			dma_data_tri_en            <= tri_en_nxt;
			dma_data_n2c               <= data_n2c_nxt;
			dma_dest_q_nearly_full_n2c <= txfifo_nearly_full; // one cycle late
			tx_pkt_len                 <= tx_pkt_len_nxt;
			rx_pkt_len                 <= rx_pkt_len_nxt;
		end
	end

	// a new ack is the op code the host put on the pins three edges before
	a_ack_requested: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		($changed(dma_op_code_ack) && dma_op_code_ack != OP_IDLE)
		|-> (dma_op_code_ack == $past(dma_op_code_req, 3)));

	// never drive valid into a bus the host owns
	a_vld_needs_tri: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		dma_vld_n2c |-> dma_data_tri_en);

endmodule

// ==== verilog/dma_word_fifo.sv ====
// show-ahead word fifo
`timescale 1ns/1ps

module dma_word_fifo #(
	parameter int WIDTH              = 36,
	parameter int DEPTH              = 16,
	parameter int NEARLY_FULL_MARGIN = 4
) (
	input  logic             cpci_clk,
	input  logic             cpci_reset,
	input  logic             wr,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             nearly_full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
	localparam logic [CW-1:0] NF_LEVEL = CW'(DEPTH - NEARLY_FULL_MARGIN);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count; // entries held

	// storage
	always_ff @(posedge cpci_clk) begin
		if (wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap
			if (rd)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	assign rd_data     = mem[rd_ptr]; // head shown ahead
	assign empty       = (count == '0);
	assign full        = (count == CW'(DEPTH));
	assign nearly_full = (count >= NF_LEVEL);

	// the users must respect the flags
	a_no_wr_full: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		!(wr && full));
	a_no_rd_empty: assert property (@(posedge cpci_clk) disable iff (cpci_reset)
		!(rd && empty));

endmodule

// ==== verilog/dma_pkg.sv ====
// dma bus engine types
`include "dma_settings.svh"

package dma_pkg;

	//////////////////////////////////////////////////
	// op codes on the req and ack pins
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OP_IDLE         = 2'b00,
		OP_STATUS_QUERY = 2'b01,
		OP_TRANSF_C2N   = 2'b10, // host to card
		OP_TRANSF_N2C   = 2'b11  // card to host
	} dma_op_e;

	// bus fsm states
	typedef enum logic [3:0] {
		ST_IDLE     = 4'h0,
		ST_QUERY    = 4'h1,
		ST_C2N_QID  = 4'h2,
		ST_C2N_LEN  = 4'h3,
		ST_C2N_DATA = 4'h4,
		ST_C2N_DONE = 4'h5,
		ST_N2C_QID  = 4'h6,
		ST_N2C_LEN  = 4'h7,
		ST_N2C_DATA = 4'h8,
		ST_N2C_DONE = 4'h9
	} dma_state_e;

	//////////////////////////////////////////////////
	// fifo words
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                       is_req;      // 1 request word, 0 data word
		logic                       eop_dir;     // eop on data, 1 = n2c on request
		logic [1:0]                 valid_bytes; // 00 means all four
		logic [`DMA_DATA_WIDTH-1:0] data;        // qid in [3:0] on request
	} tx_word_t;

	typedef struct packed {
		logic                       eop;
		logic [1:0]                 valid_bytes;
		logic [`DMA_DATA_WIDTH-1:0] data;
	} rx_word_t;

endpackage

// ==== include/dma_settings.svh ====
// dma bus engine parameters
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// pin data width, also the fifo payload
`define DMA_DATA_WIDTH 32

// cpu queues, one flag bit each
`define NUM_CPU_QUEUES 4

// byte length field in the length word
`define PKT_LEN_CNT_WIDTH 11

// fifo entries
`define TX_FIFO_DEPTH 16
`define RX_FIFO_DEPTH 16

// free entries at or below which nearly full rises
`define FIFO_NEARLY_FULL_MARGIN 4

`endif
